// ==== common/rvAlu_consts.svh ====
`ifndef RVALU_CONSTS_SVH
`define RVALU_CONSTS_SVH

// datapath widths, fixed by RV32I
`define RVALU_XLEN   32
`define RVALU_NREGS  32
`define RVALU_RIDX_W 5       // register index width
`define RVALU_ADR_W  8       // wishbone byte address width
`define RVALU_SEL_W  4       // byte lanes, only whole words are used

// wishbone address map (byte addresses)
`define RVALU_ADDR_INSTR    8'h00  // write only, issues an instruction
`define RVALU_ADDR_STATUS   8'h04  // read only: bit 0 illegal, bit 1 busy
`define RVALU_ADDR_REG_BASE 8'h80  // xN at base + 4*N

// status word bit positions
`define RVALU_ST_ILLEGAL 0
`define RVALU_ST_BUSY    1

// opcodes handled by the engine
`define RVALU_OPC_OP    7'h33
`define RVALU_OPC_OPIMM 7'h13

`define RVALU_F7_ALT 7'h20   // SUB / SRA / SRAI

`endif

// ==== common/rvAluPkg.sv ====
`default_nettype none

`include "rvAlu_consts.svh"

package rvAluPkg;

  ////////////////////////////////////////////////////////////
  // alu operation, same encoding as funct3
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    aluAdd  = 3'b000,  // add, sub when funct7[5]
    aluSll  = 3'b001,
    aluSlt  = 3'b010,
    aluSltu = 3'b011,
    aluXor  = 3'b100,
    aluSrl  = 3'b101,  // srl, sra when funct7 != 0
    aluOr   = 3'b110,
    aluAnd  = 3'b111
  } aluOpE;

  ////////////////////////////////////////////////////////////
  // pipeline records
  ////////////////////////////////////////////////////////////

  // decode stage register
  typedef struct packed {
    logic                     valid;
    logic [`RVALU_XLEN-1:0]   opA;     // rs1 value
    logic [`RVALU_XLEN-1:0]   opB;     // rs2 value or sign-extended imm
    aluOpE                    op;
    logic [6:0]               funct7;  // zeroed for non-shift immediates
    logic [`RVALU_RIDX_W-1:0] rd;
  } aluReqS;

  // one register file write
  typedef struct packed {
    logic                     en;
    logic [`RVALU_RIDX_W-1:0] addr;
    logic [`RVALU_XLEN-1:0]   data;
  } regWrS;

  // instruction word handed over by the bus port
  typedef struct packed {
    logic                   valid;
    logic [`RVALU_XLEN-1:0] instr;
  } issueS;

  // register write coming straight from the bus
  typedef struct packed {
    logic                     en;
    logic [`RVALU_RIDX_W-1:0] addr;
    logic [`RVALU_XLEN-1:0]   data;
  } hostWrS;

endpackage

`default_nettype wire

// ==== alu/alu.sv ====
`default_nettype none

`include "rvAlu_consts.svh"

// RV32I integer ALU, purely combinational
module alu import rvAluPkg::*; (
  input  logic [`RVALU_XLEN-1:0] a,
  input  logic [`RVALU_XLEN-1:0] b,
  input  aluOpE                  aluOp,
  input  logic [6:0]             funct7,
  output logic [`RVALU_XLEN-1:0] out
);

  logic [4:0] shamt;  // only the low 5 bits of b shift

  assign shamt = b[4:0];

  always_comb begin
    out = '0;  // default, keeps the block latch free

    case (aluOp)
      aluAdd: begin
        if (funct7[5]) out = a - b;  // SUB
        else out = a + b;            // ADD / ADDI
      end

      aluSll: out = a << shamt;

      aluSlt: begin  // SLT / SLTI
        if ($signed(a) < $signed(b)) out = `RVALU_XLEN'd1;
        else out = '0;
      end

      aluSltu: begin  // SLTU / SLTIU
        if (a < b) out = `RVALU_XLEN'd1;
        else out = '0;
      end

      aluXor: out = a ^ b;

      aluSrl: begin
        // funct7 of zero means logical, anything else arithmetic
        if (funct7 == 7'b0000000) out = a >> shamt;
        else out = $signed(a) >>> shamt;
      end

      aluOr:  out = a | b;

      aluAnd: out = a & b;

      default: out = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`default_nettype none

`include "rvAlu_consts.svh"

module regFile import rvAluPkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic [`RVALU_RIDX_W-1:0] rs1Addr,
  input  logic [`RVALU_RIDX_W-1:0] rs2Addr,
  output logic [`RVALU_XLEN-1:0]   rs1Data,
  output logic [`RVALU_XLEN-1:0]   rs2Data,
  input  logic [`RVALU_RIDX_W-1:0] hostRdAddr,
  output logic [`RVALU_XLEN-1:0]   hostRdData,
  input  regWrS                    wr
);

  // x1..x31 only, x0 has no storage
  logic [`RVALU_XLEN-1:0] regs [1:`RVALU_NREGS-1];

  // three combinational read ports, x0 reads as zero
  assign rs1Data    = (rs1Addr == '0) ? '0 : regs[rs1Addr];
  assign rs2Data    = (rs2Addr == '0) ? '0 : regs[rs2Addr];
  assign hostRdData = (hostRdAddr == '0) ? '0 : regs[hostRdAddr];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < `RVALU_NREGS; i++) begin
        regs[i] <= '0;  // every register starts at zero
      end
    end else if (wr.en && (wr.addr != '0)) begin  // writes to x0 vanish
      regs[wr.addr] <= wr.data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/wbHostPort.sv ====
`default_nettype none

`include "rvAlu_consts.svh"

// wishbone classic slave in front of the engine
module wbHostPort import rvAluPkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  // wishbone side
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  logic [`RVALU_ADR_W-1:0]  adr,
  input  logic [`RVALU_XLEN-1:0]   datW,
  input  logic [`RVALU_SEL_W-1:0]  sel,   // whole words only, lanes not decoded
  output logic                     ack,
  output logic [`RVALU_XLEN-1:0]   datR,
  // pipe side
  input  logic                     busy,
  input  logic                     illegal,
  output issueS                    issue,
  output hostWrS                   hostWr,
  output logic                     clrIllegal,
  // register file host read port
  output logic [`RVALU_RIDX_W-1:0] hostRdAddr,
  input  logic [`RVALU_XLEN-1:0]   hostRdData
);

  logic [`RVALU_ADR_W-1:0] wordAdr;    // byte address with lane bits dropped
  logic                    hitInstr;
  logic                    hitStatus;
  logic                    hitReg;
  logic                    statusRd;   // status read, never held off
  logic                    holdOff;
  logic                    ackNext;
  logic [`RVALU_XLEN-1:0]  statusWord;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////
  assign wordAdr   = {adr[`RVALU_ADR_W-1:2], 2'b00};
  assign hitInstr  = wordAdr == `RVALU_ADDR_INSTR;
  assign hitStatus = wordAdr == `RVALU_ADDR_STATUS;
  assign hitReg    = wordAdr >= `RVALU_ADDR_REG_BASE;  // upper half of the map

  // register index sits right above the lane bits
  assign hostRdAddr = adr[`RVALU_RIDX_W+1:2];

  always_comb begin
    statusWord = '0;
    statusWord[`RVALU_ST_ILLEGAL] = illegal;
    statusWord[`RVALU_ST_BUSY]    = busy;
  end

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////
  assign statusRd = hitStatus && !we;
  assign holdOff  = busy && !statusRd;           // wait for the pipe to drain
  assign ackNext  = cyc && stb && !ack && !holdOff;  // one ack per request

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ack        <= 1'b0;
      datR       <= '0;
      issue      <= '0;
      hostWr     <= '0;
      clrIllegal <= 1'b0;
    end else begin
      ack <= ackNext;

      // side effects line up with the ack cycle
      issue.valid <= ackNext && we && hitInstr;
      issue.instr <= datW;
      hostWr.en   <= ackNext && we && hitReg;
      hostWr.addr <= hostRdAddr;
      hostWr.data <= datW;
      clrIllegal  <= ackNext && statusRd;   // reading status clears the flag

      if (ackNext && !we) begin
        if (hitStatus) datR <= statusWord;
        else if (hitReg) datR <= hostRdData;
        else datR <= '0;                    // unmapped reads return zero
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/execPipe.sv ====
`default_nettype none

`include "rvAlu_consts.svh"

// decode -> alu -> writeback, one instruction at a time
module execPipe import rvAluPkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  input  issueS                    issue,
  input  hostWrS                   hostWr,
  input  logic                     clrIllegal,
  output logic                     busy,
  output logic                     illegal,
  output logic [`RVALU_RIDX_W-1:0] rs1Addr,
  output logic [`RVALU_RIDX_W-1:0] rs2Addr,
  input  logic [`RVALU_XLEN-1:0]   rs1Data,
  input  logic [`RVALU_XLEN-1:0]   rs2Data,
  output regWrS                    wr
);

  // instruction fields
  logic [6:0]               opcode;
  logic [6:0]               funct7;
  aluOpE                    op;       // funct3 taken as alu op
  logic [`RVALU_RIDX_W-1:0] rd;
  logic [`RVALU_XLEN-1:0]   immI;
  logic                     isOp;
  logic                     isOpImm;
  logic                     f7Ok;
  logic                     legal;

  logic [`RVALU_XLEN-1:0]   rs1Val;   // after bypass
  logic [`RVALU_XLEN-1:0]   rs2Val;
  aluReqS                   reqNext;
  aluReqS                   aluReq;   // decode stage register
  logic [`RVALU_XLEN-1:0]   aluOut;
  regWrS                    wbQ;      // writeback stage register

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////
  assign opcode  = issue.instr[6:0];
  assign rd      = issue.instr[11:7];
  assign op      = aluOpE'(issue.instr[14:12]);
  assign rs1Addr = issue.instr[19:15];
  assign rs2Addr = issue.instr[24:20];
  assign funct7  = issue.instr[31:25];
  assign immI    = {{(`RVALU_XLEN-12){issue.instr[31]}}, issue.instr[31:20]};

  assign isOp    = opcode == `RVALU_OPC_OP;
  assign isOpImm = opcode == `RVALU_OPC_OPIMM;

  always_comb begin
    f7Ok = 1'b1;  // plain immediates carry no funct7
    if (isOp) begin
      // only ADD/SUB and SRL/SRA have an alternate form
      f7Ok = (funct7 == 7'd0) ||
             ((funct7 == `RVALU_F7_ALT) && ((op == aluAdd) || (op == aluSrl)));
    end else if (op == aluSll) begin
      f7Ok = funct7 == 7'd0;                               // SLLI
    end else if (op == aluSrl) begin
      f7Ok = (funct7 == 7'd0) || (funct7 == `RVALU_F7_ALT);  // SRLI / SRAI
    end
  end

  assign legal = (isOp || isOpImm) && f7Ok;

  // bypass from the pending writeback, normally idle since busy holds the bus
  assign rs1Val = (wbQ.en && (wbQ.addr == rs1Addr) && (rs1Addr != '0)) ? wbQ.data : rs1Data;
  assign rs2Val = (wbQ.en && (wbQ.addr == rs2Addr) && (rs2Addr != '0)) ? wbQ.data : rs2Data;

  always_comb begin
    reqNext.valid = issue.valid && legal;
    reqNext.opA   = rs1Val;
    reqNext.opB   = isOp ? rs2Val : immI;   // shamt lands in opB[4:0]
    reqNext.op    = op;
    reqNext.rd    = rd;
    // imm high bits must not look like a subtract, keep funct7 for shifts only
    if (isOp || (op == aluSll) || (op == aluSrl)) reqNext.funct7 = funct7;
    else reqNext.funct7 = 7'd0;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) aluReq <= '0;
    else aluReq <= reqNext;   // edge 1
  end

  ////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////
  alu alu_inst (
    .a      (aluReq.opA),
    .b      (aluReq.opB),
    .aluOp  (aluReq.op),
    .funct7 (aluReq.funct7),
    .out    (aluOut)
  );

  ////////////////////////////////////////////////////////////
  // writeback and sticky flag
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbQ     <= '0;
      illegal <= 1'b0;
    end else begin
      wbQ.en   <= aluReq.valid;           // edge 2
      wbQ.addr <= aluReq.rd;
      wbQ.data <= aluOut;
      // a new illegal word wins over a clear in the same cycle
      if (issue.valid && !legal) illegal <= 1'b1;
      else if (clrIllegal) illegal <= 1'b0;
    end
  end

  // high until the register file has taken the result at edge 3
  assign busy = aluReq.valid || wbQ.en;

  // bus writes and pipe results never overlap, busy keeps them apart
  always_comb begin
    if (hostWr.en) begin
      wr.en   = 1'b1;
      wr.addr = hostWr.addr;
      wr.data = hostWr.data;
    end else begin
      wr.en   = wbQ.en && (wbQ.addr != '0);  // rd of x0 writes nothing
      wr.addr = wbQ.addr;
      wr.data = wbQ.data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rvAluTop.sv ====
`default_nettype none

`include "rvAlu_consts.svh"

module rvAluTop import rvAluPkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  logic [`RVALU_ADR_W-1:0] adr,
  input  logic [`RVALU_XLEN-1:0]  datW,
  input  logic [`RVALU_SEL_W-1:0] sel,
  output logic                    ack,
  output logic [`RVALU_XLEN-1:0]  datR
);

  issueS                    issue;
  hostWrS                   hostWr;
  regWrS                    wr;
  logic                     busy;
  logic                     illegal;
  logic                     clrIllegal;
  logic [`RVALU_RIDX_W-1:0] rs1Addr;
  logic [`RVALU_RIDX_W-1:0] rs2Addr;
  logic [`RVALU_RIDX_W-1:0] hostRdAddr;
  logic [`RVALU_XLEN-1:0]   rs1Data;
  logic [`RVALU_XLEN-1:0]   rs2Data;
  logic [`RVALU_XLEN-1:0]   hostRdData;

  // bus front end
  wbHostPort wbHostPort_inst (
    .clk        (clk),
    .rstN       (rstN),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .datW       (datW),
    .sel        (sel),
    .ack        (ack),
    .datR       (datR),
    .busy       (busy),
    .illegal    (illegal),
    .issue      (issue),
    .hostWr     (hostWr),
    .clrIllegal (clrIllegal),
    .hostRdAddr (hostRdAddr),
    .hostRdData (hostRdData)
  );

  // decode / execute / writeback
  execPipe execPipe_inst (
    .clk        (clk),
    .rstN       (rstN),
    .issue      (issue),
    .hostWr     (hostWr),
    .clrIllegal (clrIllegal),
    .busy       (busy),
    .illegal    (illegal),
    .rs1Addr    (rs1Addr),
    .rs2Addr    (rs2Addr),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .wr         (wr)
  );

  regFile regFile_inst (
    .clk        (clk),
    .rstN       (rstN),
    .rs1Addr    (rs1Addr),
    .rs2Addr    (rs2Addr),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .hostRdAddr (hostRdAddr),
    .hostRdData (hostRdData),
    .wr         (wr)
  );

endmodule

`default_nettype wire

// ==== dv/rvAlu_asserts.sv ====
`default_nettype none

`include "rvAlu_consts.svh"

// protocol and pipe checks, bound into the bus port and the pipe
module rvAluAsserts (
  input logic                     clk,
  input logic                     rstN,
  input logic                     cyc,
  input logic                     stb,
  input logic                     ack,
  input logic                     issueValid,
  input logic                     busy,
  input logic                     wrEn,
  input logic [`RVALU_RIDX_W-1:0] wrAddr,
  input logic                     hostWrEn   // bus write owns wr this cycle
);

  // ack only answers a live request
  ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    ack |-> (cyc && stb)) else $error("ack seen without cyc and stb");

  ackOneCycle: assert property (@(posedge clk) disable iff (!rstN)
    ack |=> !ack) else $error("ack held high for two cycles");

  // rd of x0 must be filtered before the register file
  noPipeWrX0: assert property (@(posedge clk) disable iff (!rstN)
    (wrEn && !hostWrEn) |-> (wrAddr != '0)) else $error("pipe write to x0");

  issueIdle: assert property (@(posedge clk) disable iff (!rstN)
    issueValid |-> !busy) else $error("instruction issued while busy");

endmodule

bind wbHostPort rvAluAsserts portChecks (
  .clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .ack(ack),
  .issueValid(issue.valid), .busy(busy),
  .wrEn(1'b0), .wrAddr(5'd0), .hostWrEn(1'b0)
);

bind execPipe rvAluAsserts pipeChecks (
  .clk(clk), .rstN(rstN), .cyc(1'b0), .stb(1'b0), .ack(1'b0),
  .issueValid(issue.valid), .busy(busy),
  .wrEn(wr.en), .wrAddr(wr.addr), .hostWrEn(hostWr.en)
);

`default_nettype wire

// ==== dv/rvAluTb.sv ====
`default_nettype none

`include "rvAlu_consts.svh"

module rvAluTb import rvAluPkg::*; ();

  localparam int ackTimeout = 64;   // cycles allowed per bus request
  localparam int rrCount    = 200;
  localparam int immCount   = 120;

  logic                    clk = 1'b0;
  logic                    rstN, cyc, stb, we, ack;
  logic [`RVALU_ADR_W-1:0] adr;
  logic [`RVALU_XLEN-1:0]  datW, datR;
  logic [`RVALU_SEL_W-1:0] sel;

  int                      seed;
  logic [`RVALU_XLEN-1:0]  model [0:`RVALU_NREGS-1];  // architectural registers
  logic                    modelIllegal;
  bit                      aborted;                   // set by a bus timeout
  int                      checks, mismatches, testErrs, testsRun, testsFailed;

  rvAluTop rvAluTop_inst (.clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
                          .datW(datW), .sel(sel), .ack(ack), .datR(datR));

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // wishbone master
  ////////////////////////////////////////////////////////////
  task automatic busCycle(input logic wr, input logic [`RVALU_ADR_W-1:0] a,
                          input logic [`RVALU_XLEN-1:0] d, output logic [`RVALU_XLEN-1:0] q);
    int   waitCnt;
    logic gotAck;
    q = '0;
    if (!aborted) begin
      @(posedge clk);
      cyc <= 1'b1; stb <= 1'b1; we <= wr; adr <= a; datW <= d;
      gotAck  = 1'b0;
      waitCnt = 0;
      while (!gotAck && waitCnt < ackTimeout) begin  // busy may hold us off
        @(posedge clk);
        gotAck = ack;
        q = datR;     // registered together with ack
        waitCnt++;
      end
      cyc <= 1'b0; stb <= 1'b0; we <= 1'b0;
      if (!gotAck) begin
        $display("timeout: no ack within %0d cycles for address 0x%h", ackTimeout, a);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic wbWrite(input logic [`RVALU_ADR_W-1:0] a, input logic [`RVALU_XLEN-1:0] d);
    logic [`RVALU_XLEN-1:0] unused;
    busCycle(1'b1, a, d, unused);
  endtask

  task automatic wbRead(input logic [`RVALU_ADR_W-1:0] a, output logic [`RVALU_XLEN-1:0] q);
    busCycle(1'b0, a, '0, q);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers and reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [`RVALU_ADR_W-1:0] regAdr(input logic [`RVALU_RIDX_W-1:0] idx);
    return `RVALU_ADDR_REG_BASE + {1'b0, idx, 2'b00};
  endfunction

  function automatic logic [`RVALU_XLEN-1:0] randWord();
    logic [`RVALU_XLEN-1:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic logic [`RVALU_RIDX_W-1:0] randReg();
    logic [`RVALU_XLEN-1:0] r;
    r = $random(seed);
    return r[`RVALU_RIDX_W-1:0];
  endfunction

  function automatic int unsigned pickBelow(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // corner values for compares and shifts
  function automatic logic [`RVALU_XLEN-1:0] edgeValue(input int unsigned k);
    case (k)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'h7fff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'hffff_ffff;
      default: return 32'h8000_0001;
    endcase
  endfunction

  function automatic logic [`RVALU_XLEN-1:0] rType(input logic [6:0] f7,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RVALU_OPC_OP};
  endfunction

  function automatic logic [`RVALU_XLEN-1:0] iType(input logic [11:0] imm,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `RVALU_OPC_OPIMM};
  endfunction

  function automatic regWrS makeWr(input logic [`RVALU_RIDX_W-1:0] idx);
    regWrS w;
    w.en   = 1'b1;
    w.addr = idx;
    w.data = model[idx];
    return w;
  endfunction

  // RV32I OP / OP-IMM semantics, en low for a word the engine must drop
  function automatic regWrS predictResult(input logic [`RVALU_XLEN-1:0] instr);
    regWrS                  res;
    logic [6:0]             opc, f7;
    logic [2:0]             f3;
    logic [`RVALU_XLEN-1:0] a, b;
    logic [4:0]             sh;
    logic                   isImm;
    opc   = instr[6:0];
    f3    = instr[14:12];
    f7    = instr[31:25];
    isImm = opc == `RVALU_OPC_OPIMM;
    a     = model[instr[19:15]];
    if (isImm) b = {{20{instr[31]}}, instr[31:20]};
    else b = model[instr[24:20]];
    sh = b[4:0];
    if (opc == `RVALU_OPC_OP) res.en = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
    else if (isImm && f3 == 3'd1) res.en = f7 == 7'h00;                  // SLLI
    else if (isImm && f3 == 3'd5) res.en = (f7 == 7'h00) || (f7 == 7'h20);  // SRLI / SRAI
    else res.en = isImm;
    res.addr = instr[11:7];
    res.data = '0;
    case (f3)
      3'd0: begin
        if (!isImm && instr[30]) res.data = a - b;  // only register form subtracts
        else res.data = a + b;
      end
      3'd1: res.data = a << sh;
      3'd2: res.data = {31'd0, $signed(a) < $signed(b)};
      3'd3: res.data = {31'd0, a < b};
      3'd4: res.data = a ^ b;
      3'd5: begin
        if (instr[30]) res.data = $signed(a) >>> sh;
        else res.data = a >> sh;
      end
      3'd6: res.data = a | b;
      default: res.data = a & b;
    endcase
    return res;
  endfunction

  task automatic runInstr(input logic [`RVALU_XLEN-1:0] instr, output regWrS expWr);
    regWrS res;
    res = predictResult(instr);
    if (res.en && res.addr != '0) model[res.addr] = res.data;
    if (!res.en) modelIllegal = 1'b1;
    expWr = makeWr(res.addr);
    wbWrite(`RVALU_ADDR_INSTR, instr);
  endtask

  task automatic preload(input logic [`RVALU_RIDX_W-1:0] idx, input logic [`RVALU_XLEN-1:0] v);
    wbWrite(regAdr(idx), v);
    if (idx != '0) model[idx] = v;   // x0 stays zero
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic checkWord(input string name, input logic [`RVALU_XLEN-1:0] exp,
                           input logic [`RVALU_XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h, actual 0x%h", name, exp, act);
      mismatches++; testErrs++;
    end
  endtask

  task automatic checkStatus(input string name, input logic [`RVALU_XLEN-1:0] exp,
                             input logic [`RVALU_XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("Fail %s: expected status %b, actual status %b", name, exp[1:0], act[1:0]);
      mismatches++; testErrs++;
    end
  endtask

  task automatic checkRegWr(input string name, input regWrS exp);
    logic [`RVALU_XLEN-1:0] got;
    wbRead(regAdr(exp.addr), got);
    checks++;
    if (got !== exp.data) begin
      $display("Fail %s: expected x%0d = 0x%h, actual 0x%h", name, exp.addr, exp.data, got);
      mismatches++; testErrs++;
    end
  endtask

  task automatic readStatus(input string name);
    logic [`RVALU_XLEN-1:0] got, exp;
    exp = '0;
    exp[`RVALU_ST_ILLEGAL] = modelIllegal;
    wbRead(`RVALU_ADDR_STATUS, got);
    checkStatus(name, exp, got);
    modelIllegal = 1'b0;   // the read clears the sticky flag
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (testErrs != 0) testsFailed++;
    $display("test %s finished, %0d mismatches", name, testErrs);
    testErrs = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  task automatic testResetState();
    logic [`RVALU_XLEN-1:0] got;
    for (int i = 0; i < `RVALU_NREGS; i++) begin
      wbRead(regAdr(i[4:0]), got);
      checkWord("resetState", '0, got);
    end
    readStatus("resetState");
    finishTest("resetState");
  endtask

  task automatic testRegWriteRead();
    for (int i = 1; i < `RVALU_NREGS; i++) preload(i[4:0], randWord());
    for (int i = 1; i < `RVALU_NREGS; i++) checkRegWr("regWriteRead", makeWr(i[4:0]));
    preload(5'd0, randWord());
    checkRegWr("regWriteRead", makeWr(5'd0));   // x0 ignores the write
    finishTest("regWriteRead");
  endtask

  task automatic testRegRegOps();
    logic [`RVALU_XLEN-1:0] r;
    logic [4:0]             rs1, rs2, rd;
    logic [6:0]             f7;
    regWrS                  expWr;
    for (int n = 0; n < rrCount; n++) begin
      r   = randWord();
      rs1 = randReg(); rs2 = randReg(); rd = randReg();
      f7  = ((r[2:0] == 3'd0 || r[2:0] == 3'd5) && r[3]) ? 7'h20 : 7'h00;  // SUB / SRA
      if (pickBelow(3) == 0) preload(rs1, edgeValue(pickBelow(6)));
      if (pickBelow(3) == 0) preload(rs2, edgeValue(pickBelow(6)));
      runInstr(rType(f7, rs2, rs1, r[2:0], rd), expWr);
      checkRegWr("regRegOps", expWr);
    end
    finishTest("regRegOps");
  endtask

  task automatic testImmOps();
    logic [`RVALU_XLEN-1:0] r;
    logic [4:0]             rs1, rd;
    logic [2:0]             f3;
    logic [11:0]            imm;
    regWrS                  expWr;
    for (int n = 0; n < immCount; n++) begin
      r = randWord(); rs1 = randReg(); rd = randReg();
      f3 = r[2:0]; imm = r[15:4];
      if (n % 4 == 0) begin
        f3 = 3'd0; imm[10] = 1'b1;   // ADDI whose bit 30 looks like SUB
      end else if (n % 4 == 1) begin
        f3 = 3'd5;
        preload(rs1, edgeValue(3 + pickBelow(3)));   // negative operand
      end
      if (f3 == 3'd1) imm = {7'h00, r[8:4]};
      else if (f3 == 3'd5) imm = {(r[20] ? 7'h20 : 7'h00), r[8:4]};
      if (pickBelow(4) == 0) preload(rs1, edgeValue(pickBelow(6)));
      runInstr(iType(imm, rs1, f3, rd), expWr);
      checkRegWr("immOps", expWr);
    end
    finishTest("immOps");
  endtask

  task automatic testDependence();
    logic [`RVALU_XLEN-1:0] r;
    logic [4:0]             rd1, rd2, rsA, rsB;
    regWrS                  firstWr, secondWr;
    for (int n = 0; n < 40; n++) begin
      r = randWord(); rsA = randReg(); rsB = randReg(); rd1 = randReg(); rd2 = randReg();
      if (rd1 == '0) rd1 = 5'd1;
      runInstr(rType(r[3] ? 7'h20 : 7'h00, rsB, rsA, r[3] ? 3'd0 : r[2:0], rd1), firstWr);
      // second word reads the first one's rd straight away
      runInstr(rType(7'h00, r[9] ? rd1 : rsB, rd1, r[6:4], rd2), secondWr);
      checkRegWr("dependence", makeWr(firstWr.addr));
      checkRegWr("dependence", secondWr);
    end
    finishTest("dependence");
  endtask

  task automatic testIllegal();
    logic [`RVALU_XLEN-1:0] r, instr;
    logic [6:0]             opc;
    logic [2:0]             f3;
    regWrS                  expWr;
    for (int n = 0; n < 24; n++) begin
      r = randWord();
      f3 = r[14:12];
      case (n % 4)
        0: begin
          opc = r[6:0];
          if (opc == `RVALU_OPC_OP || opc == `RVALU_OPC_OPIMM) opc = 7'h03;  // load opcode
          instr = {r[31:7], opc};
        end
        1: instr = rType(7'h01, r[24:20], r[19:15], f3, r[11:7]);  // M extension funct7
        2: begin
          if (f3 == 3'd0 || f3 == 3'd5) f3 = 3'd7;   // no alternate form here
          instr = rType(7'h20, r[24:20], r[19:15], f3, r[11:7]);
        end
        default: begin
          if (r[4]) instr = iType({7'h20, r[24:20]}, r[19:15], 3'd1, r[11:7]);
          else instr = iType({7'h10, r[24:20]}, r[19:15], 3'd5, r[11:7]);
        end
      endcase
      runInstr(instr, expWr);
      readStatus("illegal");   // flag set
      readStatus("illegal");   // cleared by the first read
    end
    for (int i = 0; i < `RVALU_NREGS; i++) checkRegWr("illegal", makeWr(i[4:0]));
    finishTest("illegal");
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed = 32'hca0c;
    rstN <= 1'b0; cyc <= 1'b0; stb <= 1'b0; we <= 1'b0;
    adr <= '0; datW <= '0; sel <= '1;
    aborted = 1'b0; modelIllegal = 1'b0;
    checks = 0; mismatches = 0; testErrs = 0; testsRun = 0; testsFailed = 0;
    for (int i = 0; i < `RVALU_NREGS; i++) model[i] = '0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    testResetState();
    testRegWriteRead();
    testRegRegOps();
    testImmOps();
    testDependence();
    testIllegal();
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d, timeout %0d",
             testsRun, testsFailed, checks, mismatches, aborted);
    if (!aborted && mismatches == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/rvAluPkg.sv
alu/alu.sv
hw/regFile.sv
hw/wbHostPort.sv
hw/execPipe.sv
hw/rvAluTop.sv
dv/rvAlu_asserts.sv
dv/rvAluTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rvAluTop testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module rvAluTb

status=0
./obj_dir/VrvAluTb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Result: FAILED" sim.log; then
  exit 1
fi
